/* src/cpu_pkg.sv */
/*
 * Shared definitions for the SAP-1 style accumulator CPU
 * Data and address widths, the instruction opcodes, the six
 * sequencer steps and the internal bus driver selection
 */

`default_nettype none

package cpu_pkg;

    localparam int data_w = 8;  // Bus, registers and RAM words
    localparam int addr_w = 4;  // Operand nibble, PC and RAM index

    // High nibble of every instruction
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LDA = 4'd1,   // Acc <- RAM[operand]
        ADD = 4'd2,   // Acc <- Acc + RAM[operand]
        SUB = 4'd3,   // Acc <- Acc - RAM[operand]
        STA = 4'd4,   // RAM[operand] <- Acc
        LDI = 4'd5,   // Acc <- operand
        JMP = 4'd6,
        JC  = 4'd7,   // Jump if carry (no borrow on SUB)
        JZ  = 4'd8,
        OUT = 4'd14,
        HLT = 4'd15
    } opcode_e;

    // Sequencer steps, T1 and T2 are the shared fetch
    typedef enum logic [2:0] {
        T1, T2, T3, T4, T5, T6
    } step_e;

    // Which peer owns the internal bus this cycle
    typedef enum logic [2:0] {
        NONE,         // Bus reads zero
        PC,
        RAM,
        IR_OPERAND,
        ACC,
        ALU
    } bus_src_e;

endpackage

`default_nettype wire

/* src/program_counter.sv */
/*
 * Program counter
 * 4-bit instruction pointer, steps on pc_inc and takes the low
 * bus nibble on pc_load, wraps from 15 back to 0
 */

`timescale 1ns/10ps
`default_nettype none

module program_counter (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           pc_inc,    // Fetch step
    input  wire                           pc_load,   // Taken jump
    input  wire  [cpu_pkg::data_w-1:0]    bus,
    output logic [cpu_pkg::addr_w-1:0]    pc_value
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_value <= '0;
        end else if (pc_load) begin
            pc_value <= bus[addr_w-1:0];  // Jump target is the operand nibble
        end else if (pc_inc) begin
            pc_value <= pc_value + 1'b1;  // Natural wrap at 4 bits
        end
    end

endmodule

`default_nettype wire

/* src/control_sequencer.sv */
/*
 * Control sequencer
 * Fixed six-step ring T1..T6 with a decoder that turns the step
 * and the current opcode into bus selection and load strobes
 * T1/T2 fetch, T3..T6 execute, HLT freezes the ring until reset
 */

`timescale 1ns/10ps
`default_nettype none

module control_sequencer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      prog_en,     // Loader owns RAM, CPU idles
    input  var  cpu_pkg::opcode_e    opcode,
    input  wire                      carry_flag,
    input  wire                      zero_flag,
    output cpu_pkg::bus_src_e        bus_src,
    output logic                     mar_load,
    output logic                     mdr_load,
    output logic                     ram_we,
    output logic                     ir_load,
    output logic                     pc_inc,
    output logic                     pc_load,
    output logic                     acc_load,
    output logic                     b_load,
    output logic                     out_load,
    output logic                     alu_sub,
    output logic                     flags_we,
    output logic                     halted
);
    import cpu_pkg::*;

    step_e step;
    step_e step_next;
    logic  run_q;    // One dead cycle after reset or a loader session
    logic  active;   // Strobes allowed this cycle

    assign active = run_q & ~prog_en & ~halted;

    always_comb begin
        case (step)
            T1:      step_next = T2;
            T2:      step_next = T3;
            T3:      step_next = T4;
            T4:      step_next = T5;
            T5:      step_next = T6;
            default: step_next = T1;  // T6 wraps to the next fetch
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step   <= T1;
            run_q  <= 1'b0;
            halted <= 1'b0;
        end else begin
            run_q <= ~prog_en;
            if (active && step == T3 && opcode == HLT)
                halted <= 1'b1;           // Sticky until reset
            if (!halted) begin
                if (prog_en)     step <= T1;
                else if (active) step <= step_next;
            end
        end
    end

    // Strobe decode
    always_comb begin
        bus_src  = NONE;
        mar_load = 1'b0;
        mdr_load = 1'b0;
        ram_we   = 1'b0;
        ir_load  = 1'b0;
        pc_inc   = 1'b0;
        pc_load  = 1'b0;
        acc_load = 1'b0;
        b_load   = 1'b0;
        out_load = 1'b0;
        alu_sub  = 1'b0;
        flags_we = 1'b0;
        if (active) begin
            case (step)
                T1: begin
                    bus_src  = PC;      // Address of next instruction
                    mar_load = 1'b1;
                end
                T2: begin
                    bus_src = RAM;
                    ir_load = 1'b1;
                    pc_inc  = 1'b1;
                end
                default: begin
                    case (opcode)
                        LDA, ADD, SUB, STA: begin
                            // Operand addresses RAM first
                            if (step == T3) begin
                                bus_src  = IR_OPERAND;
                                mar_load = 1'b1;
                            end else if (step == T4 && opcode == STA) begin
                                bus_src  = ACC;
                                mdr_load = 1'b1;
                            end else if (step == T4) begin
                                bus_src  = RAM;
                                acc_load = (opcode == LDA);
                                b_load   = (opcode != LDA);
                            end else if (step == T5 && opcode == STA) begin
                                ram_we = 1'b1;   // Write-data register into RAM
                            end else if (step == T5 && opcode != LDA) begin
                                bus_src  = ALU;
                                alu_sub  = (opcode == SUB);
                                acc_load = 1'b1;
                                flags_we = 1'b1;
                            end
                        end
                        LDI, JMP, JC, JZ: begin
                            if (step == T3) begin
                                bus_src  = IR_OPERAND;
                                acc_load = (opcode == LDI);
                                pc_load  = (opcode == JMP) |
                                           (opcode == JC && carry_flag) |
                                           (opcode == JZ && zero_flag);
                            end
                        end
                        OUT: begin
                            if (step == T3) begin
                                bus_src  = ACC;
                                out_load = 1'b1;
                            end
                        end
                        default: ;    // NOP, HLT and unused codes idle
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
/*
 * ALU
 * Combinational add or two's complement subtract of B from the
 * accumulator, with carry and zero flags held in registers
 */

`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [cpu_pkg::data_w-1:0]   acc_value,
    input  wire  [cpu_pkg::data_w-1:0]   b_value,
    input  wire                          alu_sub,   // 1 = Acc - B
    input  wire                          flags_we,
    output logic [cpu_pkg::data_w-1:0]   alu_result,
    output logic                         carry_flag,
    output logic                         zero_flag
);
    import cpu_pkg::*;

    logic [data_w:0]   sum_ext;   // Extra bit is the carry out
    logic [data_w-1:0] b_opnd;

    assign b_opnd     = alu_sub ? ~b_value : b_value;
    // Carry in of 1 completes the two's complement, carry out means A >= B
    assign sum_ext    = {1'b0, acc_value} + {1'b0, b_opnd} + {{data_w{1'b0}}, alu_sub};
    assign alu_result = sum_ext[data_w-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry_flag <= 1'b0;
            zero_flag  <= 1'b0;
        end else if (flags_we) begin
            carry_flag <= sum_ext[data_w];
            zero_flag  <= (alu_result == '0);
        end
    end

endmodule

`default_nettype wire

/* src/data_registers.sv */
/*
 * Data registers
 * Accumulator, B, instruction and output registers, each loaded
 * from the internal bus on its own strobe
 * The instruction register splits into opcode and operand
 */

`timescale 1ns/10ps
`default_nettype none

module data_registers (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [cpu_pkg::data_w-1:0]   bus,
    input  wire                          ir_load,
    input  wire                          acc_load,
    input  wire                          b_load,
    input  wire                          out_load,
    output cpu_pkg::opcode_e             opcode,
    output logic [cpu_pkg::data_w-1:0]   ir_operand,
    output logic [cpu_pkg::data_w-1:0]   acc_value,
    output logic [cpu_pkg::data_w-1:0]   b_value,
    output logic [cpu_pkg::data_w-1:0]   out_value
);
    import cpu_pkg::*;

    logic [data_w-1:0] ir_q;

    assign opcode     = opcode_e'(ir_q[data_w-1:addr_w]);          // High nibble
    assign ir_operand = {{(data_w-addr_w){1'b0}}, ir_q[addr_w-1:0]};  // Zero extended

    // Instruction, accumulator and output start cleared
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_q      <= '0;     // Decodes as NOP
            acc_value <= '0;
            out_value <= '0;
        end else begin
            if (ir_load)  ir_q      <= bus;
            if (acc_load) acc_value <= bus;
            if (out_load) out_value <= bus;   // Only OUT moves the display
        end
    end

    // B holds the second ALU operand
    always_ff @(posedge clk) begin
        if (b_load) b_value <= bus;
    end

endmodule

`default_nettype wire

/* src/memory_unit.sv */
/*
 * Memory unit
 * Memory-address register and write-data register in front of a
 * 16-byte RAM, asynchronous read and synchronous write on the
 * port granted by the bus arbiter
 */

`timescale 1ns/10ps
`default_nettype none

module memory_unit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [cpu_pkg::data_w-1:0]   bus,
    input  wire                          mar_load,
    input  wire                          mdr_load,
    input  wire  [cpu_pkg::addr_w-1:0]   mem_addr_sel,    // Granted address
    input  wire  [cpu_pkg::data_w-1:0]   mem_wdata_sel,   // Granted write data
    input  wire                          mem_we_sel,      // Granted write enable
    output logic [cpu_pkg::addr_w-1:0]   mar_value,
    output logic [cpu_pkg::data_w-1:0]   mdr_value,
    output logic [cpu_pkg::data_w-1:0]   ram_rdata
);
    import cpu_pkg::*;

    localparam int depth = 1 << addr_w;   // 16 bytes

    logic [data_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar_value <= '0;
        end else if (mar_load) begin
            mar_value <= bus[addr_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (mdr_load) mdr_value <= bus;   // Accumulator on its way to RAM
    end

    // RAM array, cleared at reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) mem[i] <= '0;
        end else if (mem_we_sel) begin
            mem[mem_addr_sel] <= mem_wdata_sel;
        end
    end

    assign ram_rdata = mem[mem_addr_sel];   // Asynchronous read

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
/*
 * Bus arbiter
 * Picks the single driver of the internal bus and grants the RAM
 * port to the program loader while prog_en is high
 */

`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  var  cpu_pkg::bus_src_e       bus_src,
    input  wire [cpu_pkg::addr_w-1:0]    pc_value,
    input  wire [cpu_pkg::data_w-1:0]    ram_rdata,
    input  wire [cpu_pkg::data_w-1:0]    ir_operand,
    input  wire [cpu_pkg::data_w-1:0]    acc_value,
    input  wire [cpu_pkg::data_w-1:0]    alu_result,
    input  wire                          prog_en,
    input  wire [cpu_pkg::addr_w-1:0]    prog_addr,
    input  wire [cpu_pkg::data_w-1:0]    prog_data,
    input  wire                          prog_we,
    input  wire [cpu_pkg::addr_w-1:0]    mar_value,
    input  wire [cpu_pkg::data_w-1:0]    mdr_value,
    input  wire                          ram_we,
    output logic [cpu_pkg::data_w-1:0]   bus,
    output logic [cpu_pkg::addr_w-1:0]   mem_addr_sel,
    output logic [cpu_pkg::data_w-1:0]   mem_wdata_sel,
    output logic                         mem_we_sel
);
    import cpu_pkg::*;

    // Driver mux
    always_comb begin
        case (bus_src)
            PC:         bus = {{(data_w-addr_w){1'b0}}, pc_value};
            RAM:        bus = ram_rdata;
            IR_OPERAND: bus = ir_operand;
            ACC:        bus = acc_value;
            ALU:        bus = alu_result;
            default:    bus = '0;          // NONE, idle bus
        endcase
    end

    // RAM port grant, loader wins outright
    assign mem_addr_sel  = prog_en ? prog_addr : mar_value;
    assign mem_wdata_sel = prog_en ? prog_data : mdr_value;
    assign mem_we_sel    = prog_en ? prog_we   : ram_we;

endmodule

`default_nettype wire

/* src/cpu_top.sv */
/*
 * SAP-1 style CPU top level
 * Ties the sequencer, PC, ALU, registers and memory to the one
 * internal bus and exposes the loader port, output and halt
 */

`timescale 1ns/10ps
`default_nettype none

module cpu_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          prog_en,     // Loader session
    input  wire                          prog_we,
    input  wire  [cpu_pkg::addr_w-1:0]   prog_addr,
    input  wire  [cpu_pkg::data_w-1:0]   prog_data,
    output logic [cpu_pkg::data_w-1:0]   out_value,
    output logic                         halted
);
    import cpu_pkg::*;

    logic [data_w-1:0] bus;
    bus_src_e          bus_src;
    opcode_e           opcode;

    // Strobes from the sequencer
    logic mar_load, mdr_load, ram_we, ir_load, pc_inc, pc_load;
    logic acc_load, b_load, out_load, alu_sub, flags_we;

    logic              carry_flag, zero_flag;
    logic [addr_w-1:0] pc_value, mar_value, mem_addr_sel;
    logic [data_w-1:0] ram_rdata, ir_operand, acc_value, b_value, alu_result;
    logic [data_w-1:0] mdr_value, mem_wdata_sel;
    logic              mem_we_sel;

    control_sequencer seq_i (
        .clk, .rst_n, .prog_en, .opcode, .carry_flag, .zero_flag, .bus_src,
        .mar_load, .mdr_load, .ram_we, .ir_load, .pc_inc, .pc_load,
        .acc_load, .b_load, .out_load, .alu_sub, .flags_we, .halted
    );

    program_counter pc_i (
        .clk, .rst_n, .pc_inc, .pc_load, .bus, .pc_value
    );

    alu alu_i (
        .clk, .rst_n, .acc_value, .b_value, .alu_sub, .flags_we,
        .alu_result, .carry_flag, .zero_flag
    );

    data_registers regs_i (
        .clk, .rst_n, .bus, .ir_load, .acc_load, .b_load, .out_load,
        .opcode, .ir_operand, .acc_value, .b_value, .out_value
    );

    memory_unit mem_i (
        .clk, .rst_n, .bus, .mar_load, .mdr_load,
        .mem_addr_sel, .mem_wdata_sel, .mem_we_sel,
        .mar_value, .mdr_value, .ram_rdata
    );

    // Bus driver select and RAM port grant
    bus_arbiter arb_i (
        .bus_src, .pc_value, .ram_rdata, .ir_operand, .acc_value, .alu_result,
        .prog_en, .prog_addr, .prog_data, .prog_we,
        .mar_value, .mdr_value, .ram_we,
        .bus, .mem_addr_sel, .mem_wdata_sel, .mem_we_sel
    );

endmodule

`default_nettype wire

/* test/cpu_props.sv */
/*
 * Control properties bound to the CPU top level
 * Halt is sticky, and the output and every load strobe stay quiet
 * while the program loader owns the RAM
 */

`timescale 1ns/10ps
`default_nettype none

module cpu_props (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         prog_en,
    input wire                         halted,
    input wire [cpu_pkg::data_w-1:0]   out_value,
    input wire [9:0]                   load_strobes   // Every strobe of the sequencer
);
    int fail_count = 0;   // Property failures so far

    // Only a reset edge may clear halted
    assert property (@(posedge clk) $past(rst_n) |-> !$fell(halted))
        else begin
            fail_count++;
            $error("halted fell while out of reset");
        end

    assert property (@(posedge clk) ($past(prog_en) && $past(rst_n)) |-> $stable(out_value))
        else begin
            fail_count++;
            $error("out_value changed during a loader session");
        end

    assert property (@(posedge clk) prog_en |-> (load_strobes == '0))
        else begin
            fail_count++;
            $error("load strobe fired during a loader session");
        end

endmodule

bind cpu_top cpu_props props_i (
    .clk, .rst_n, .prog_en, .halted, .out_value,
    .load_strobes({mar_load, mdr_load, ram_we, ir_load, pc_inc, pc_load,
                   acc_load, b_load, out_load, flags_we})
);

`default_nettype wire

/* test/cpu_tb.sv */
/*
 * Testbench for the SAP-1 style CPU
 * Loads each program through the loader port, runs it to HLT and
 * compares out_value with a software model of the instruction set
 */

`timescale 1ns/10ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int num_tests  = 12;
    // Load plus 16 instructions per test, then reset, hold and slack
    localparam int max_cycles = num_tests * (16 + 16 * 6) + num_tests * 16 + 50 + 200;

    logic              clk;
    logic              rst_n;
    logic              prog_en;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;
    logic [data_w-1:0] prog_data;
    logic [data_w-1:0] out_value;
    logic              halted;

    logic [data_w-1:0] prog_mem [16];   // Image for the loader and the model
    int                errors = 0;
    int                passes = 0;
    int                cycles = 0;

    cpu_top dut_i (
        .clk, .rst_n, .prog_en, .prog_we, .prog_addr, .prog_data,
        .out_value, .halted
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, the CPU never reached HLT", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Unused cells get an idle opcode tagged with their address
    function automatic void clear_program();
        for (int i = 0; i < 16; i++) begin
            prog_mem[i] = {4'hA, i[3:0]};
        end
    endfunction

    function automatic void put_instr(input int addr, input opcode_e op, input logic [3:0] opr);
        prog_mem[addr] = {op, opr};
    endfunction

    // ISA reference bounded so a looping program cannot hang it
    function automatic logic [7:0] model_out();
        logic [7:0] mem [16];
        logic [3:0] pc;
        logic [3:0] op;
        logic [3:0] opr;
        logic [7:0] acc;
        logic [7:0] b;
        logic [7:0] outv;
        logic [8:0] sum;
        logic       cf;
        logic       zf;
        mem  = prog_mem;
        pc   = '0;
        acc  = '0;
        outv = '0;
        cf   = 1'b0;
        zf   = 1'b0;
        for (int n = 0; n < 64; n++) begin
            op  = mem[pc][7:4];
            opr = mem[pc][3:0];
            pc  = pc + 4'd1;
            if (op == HLT) break;
            case (op)
                LDA: acc = mem[opr];
                ADD, SUB: begin
                    b   = mem[opr];
                    sum = (op == SUB) ? {1'b0, acc} - {1'b0, b} : {1'b0, acc} + {1'b0, b};
                    cf  = (op == SUB) ? (acc >= b) : sum[8];   // No borrow on SUB
                    acc = sum[7:0];
                    zf  = (acc == 8'h00);
                end
                STA: mem[opr] = acc;
                LDI: acc = {4'h0, opr};
                JMP: pc = opr;
                JC:  if (cf) pc = opr;
                JZ:  if (zf) pc = opr;
                OUT: outv = acc;
                default: ;   // NOP and unused codes
            endcase
        end
        return outv;
    endfunction

    task automatic run_test(input string name, input bit hold_check);
        logic [7:0] expected;
        logic [7:0] held;
        int         errs_before;
        expected    = model_out();
        errs_before = errors;
        rst_n   = 1'b0;
        prog_en = 1'b1;              // Keeps the CPU at T1 with PC 0 after reset
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 16; i++) begin
            prog_addr = i[addr_w-1:0];
            prog_data = prog_mem[i];
            prog_we   = 1'b1;
            @(negedge clk);
        end
        prog_we = 1'b0;
        prog_en = 1'b0;
        while (!halted) @(negedge clk);
        assert (out_value == expected) else begin
            $display("[FAIL] %s: out_value = %h, expected %h", name, out_value, expected);
            errors++;
        end
        if (hold_check) begin
            held = out_value;
            repeat (50) begin
                @(negedge clk);
                assert (halted) else begin
                    $display("%s: halted dropped after HLT", name);
                    errors++;
                end
                assert (out_value == held) else begin
                    $display("[FAIL] %s: out_value = %h, expected %h", name, out_value, held);
                    errors++;
                end
            end
        end
        if (errors == errs_before) begin
            passes++;
            $display("test %s ok, out_value = %h", name, out_value);
        end else begin
            $display("test %s failed", name);
        end
    endtask

    // Two operand program with a conditional jump to a second OUT
    task automatic branch_test(input string name, input opcode_e jop, input opcode_e aop,
                               input logic [7:0] a, input logic [7:0] b);
        clear_program();
        put_instr(0, LDA, 4'd14);
        put_instr(1, aop, 4'd15);
        put_instr(2, jop, 4'd6);
        put_instr(3, LDI, 4'd1);    // Fall-through path
        put_instr(4, OUT, 4'd0);
        put_instr(5, HLT, 4'd0);
        put_instr(6, LDI, 4'd2);    // Taken path
        put_instr(7, OUT, 4'd0);
        put_instr(8, HLT, 4'd0);
        prog_mem[14] = a;
        prog_mem[15] = b;
        run_test(name, 1'b0);
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(32'h8b4b));
        rst_n     = 1'b0;
        prog_en   = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        @(negedge clk);
        rnd = $urandom;
        clear_program();
        put_instr(0, LDI, rnd[3:0]);
        put_instr(1, OUT, 4'd0);
        put_instr(2, HLT, 4'd0);
        run_test("ldi_out", 1'b0);
        clear_program();
        put_instr(0, LDA, 4'd15);
        put_instr(1, OUT, 4'd0);
        put_instr(2, HLT, 4'd0);
        prog_mem[15] = 8'($urandom);
        run_test("lda_out", 1'b0);
        // Random operands with a forced wrap in the first ADD and the first SUB
        for (int k = 0; k < 4; k++) begin
            clear_program();
            put_instr(0, LDA, 4'd14);
            put_instr(1, opcode_e'((k < 2) ? ADD : SUB), 4'd15);
            put_instr(2, OUT, 4'd0);
            put_instr(3, HLT, 4'd0);
            prog_mem[14] = 8'($urandom);
            prog_mem[15] = 8'($urandom);
            if (k == 0) begin
                prog_mem[14][7] = 1'b1;   // Both high bits set so the sum wraps
                prog_mem[15][7] = 1'b1;
            end else if (k == 2) begin
                prog_mem[14][7] = 1'b0;   // A below B so the difference wraps
                prog_mem[15][7] = 1'b1;
            end
            run_test((k < 2) ? "add_rand" : "sub_rand", 1'b0);
        end
        clear_program();
        put_instr(0, LDA, 4'd14);
        put_instr(1, ADD, 4'd15);
        put_instr(2, STA, 4'd13);
        put_instr(3, LDI, 4'd0);    // Wipe the accumulator before reading back
        put_instr(4, LDA, 4'd13);
        put_instr(5, OUT, 4'd0);
        put_instr(6, HLT, 4'd0);
        prog_mem[14] = 8'($urandom);
        prog_mem[15] = 8'($urandom);
        run_test("sta_lda", 1'b0);
        branch_test("jc_taken", JC, ADD, 8'hC8, 8'h40);
        branch_test("jc_fall", JC, ADD, 8'h10, 8'h20);
        branch_test("jz_taken", JZ, SUB, 8'h37, 8'h37);
        branch_test("jz_fall", JZ, SUB, 8'h37, 8'h12);
        clear_program();
        put_instr(0, LDI, 4'd3);
        put_instr(1, JMP, 4'd3);
        put_instr(2, LDI, 4'd7);    // Skipped
        put_instr(3, OUT, 4'd0);
        put_instr(4, HLT, 4'd0);
        put_instr(5, LDI, 4'd9);    // Never reached after HLT
        put_instr(6, OUT, 4'd0);
        run_test("jmp_halt", 1'b1);
        $display("tests: %0d run, %0d passed, %0d check errors, %0d property failures",
                 num_tests, passes, errors, dut_i.props_i.fail_count);
        if (errors == 0 && passes == num_tests && dut_i.props_i.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
src/cpu_pkg.sv
src/program_counter.sv
src/control_sequencer.sv
src/alu.sv
src/data_registers.sv
src/memory_unit.sv
src/bus_arbiter.sv
src/cpu_top.sv
test/cpu_props.sv
test/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module cpu_tb -f files.f -o cpu_sim

sim_out=$(./obj_dir/cpu_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASSED"
